/* source/axil_pkg.sv */
/*
 * AXI4-Lite bus definitions: widths, response codes,
 * per-channel payload structs and the request/response bundles
 */
`default_nettype none

package axil_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [2:0]           prot;
  } aw_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [2:0]           prot;
  } ar_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
  } w_t;

  typedef struct packed {
    resp_e resp;
  } b_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    resp_e                resp;
  } r_t;

  // master -> slave
  typedef struct packed {
    aw_t  aw;
    logic aw_valid;
    w_t   w;
    logic w_valid;
    logic b_ready;
    ar_t  ar;
    logic ar_valid;
    logic r_ready;
  } req_t;

  // slave -> master
  typedef struct packed {
    logic aw_ready;
    logic w_ready;
    b_t   b;
    logic b_valid;
    logic ar_ready;
    r_t   r;
    logic r_valid;
  } resp_t;

endpackage

`default_nettype wire

/* source/soc_map_pkg.sv */
/*
 * SoC address map: region indices, base and length of the boot ROM
 * and the CLINT, CLINT register offsets and the boot image contents
 */
`default_nettype none

package soc_map_pkg;

  localparam int unsigned NrSlaves = 2;

  typedef enum logic [0:0] {
    ROM_IDX   = 1'b0,
    CLINT_IDX = 1'b1
  } slave_idx_e;

  localparam logic [31:0] RomBase     = 32'h0001_0000;
  localparam logic [31:0] RomLength   = 32'h0001_0000;
  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] ClintLength = 32'h0000_C000;

  // clint register offsets, 64-bit aligned
  localparam logic [15:0] MsipOffset     = 16'h0000;
  localparam logic [15:0] MtimecmpOffset = 16'h4000;
  localparam logic [15:0] MtimeOffset    = 16'hBFF8;

  localparam int unsigned BootImageWords = 8;

  localparam logic [63:0] BootImage [BootImageWords] = '{
    64'h0000_0013_0000_0000, 64'h0000_0013_0000_0101,
    64'h0000_0013_0000_0202, 64'h0000_0013_0000_0303,
    64'h0000_0013_0000_0404, 64'h0000_0013_0000_0505,
    64'h0000_0013_0000_0606, 64'h0000_0013_0000_0707
  };

endpackage

`default_nettype wire

/* source/reset_gen.sv */
/*
 * System reset generator: PLL lock combined with the external
 * reset, asserted asynchronously, released through a flop chain
 */
`timescale 1ns/1ps
`default_nettype none

module reset_gen #(
  parameter int unsigned SyncStages = 2
) (
  input  wire logic clk,
  input  wire logic ndmreset_n,
  input  wire logic pll_locked_i,
  output logic      sys_rst_n_o
);

  logic                  rst_comb_n;
  logic [SyncStages-1:0] sync_q;

  assign rst_comb_n = ndmreset_n & pll_locked_i;

  always_ff @(posedge clk or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= (sync_q << 1) | SyncStages'(1); // shift in ones
    end
  end

  assign sys_rst_n_o = sync_q[SyncStages-1];

  // the system must never run without a locked clock
  assert property (@(posedge clk) !pll_locked_i |-> !sys_rst_n_o);

endmodule

`default_nettype wire

/* source/axil_slice.sv */
/*
 * Single-entry register slice for a valid/ready channel,
 * payload type set by parameter
 */
`timescale 1ns/1ps
`default_nettype none

module axil_slice #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     rst_n_i,
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  input  wire payload_t in_data_i,
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  output payload_t      out_data_o
);

  logic     full_q;
  payload_t data_q;

  // refill in the same cycle the held item leaves
  assign in_ready_o  = !full_q || out_ready_i;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

/* source/axil_xbar.sv */
/*
 * AXI4-Lite interconnect for one master with address decode,
 * target tracking for one read and one write in flight, register
 * slices on AR and R, and a decode-error responder for unmapped space
 */
`timescale 1ns/1ps
`default_nettype none

module axil_xbar (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire axil_pkg::req_t  slv_req_i,
  output axil_pkg::resp_t      slv_resp_o,
  output axil_pkg::req_t       mst_req_o [soc_map_pkg::NrSlaves],
  input  wire axil_pkg::resp_t mst_resp_i [soc_map_pkg::NrSlaves]
);

  localparam int unsigned NrTgt  = soc_map_pkg::NrSlaves + 1;
  localparam int unsigned ErrIdx = soc_map_pkg::NrSlaves; // last target
  localparam int unsigned SelW   = $clog2(NrTgt);

  axil_pkg::req_t  tgt_req  [NrTgt];
  axil_pkg::resp_t tgt_resp [NrTgt];

  axil_pkg::ar_t   ar_out;
  axil_pkg::r_t    r_in;
  axil_pkg::r_t    r_out;
  logic            ar_in_valid, ar_in_ready, ar_out_valid, ar_out_ready;
  logic            r_in_valid, r_in_ready, r_out_valid;
  logic [SelW-1:0] rd_sel, rd_sel_q, wr_sel, wr_sel_q;
  logic            rd_busy_q, rd_pend_q, wr_pend_q;
  logic            err_b_q, err_r_q;

  function automatic logic [SelW-1:0] decode(input logic [axil_pkg::AddrWidth-1:0] addr);
    if ((addr - soc_map_pkg::RomBase) < soc_map_pkg::RomLength) begin
      return SelW'(soc_map_pkg::ROM_IDX);
    end
    if ((addr - soc_map_pkg::ClintBase) < soc_map_pkg::ClintLength) begin
      return SelW'(soc_map_pkg::CLINT_IDX);
    end
    return SelW'(ErrIdx);
  endfunction

  assign rd_sel = decode(ar_out.addr);
  assign wr_sel = decode(slv_req_i.aw.addr);

  // --------------------------------------------------
  // read path
  // --------------------------------------------------
  assign ar_in_valid = slv_req_i.ar_valid && !rd_busy_q; // one read at a time

  axil_slice #(.payload_t(axil_pkg::ar_t)) ar_slice_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (ar_in_valid),
    .in_ready_o  (ar_in_ready),
    .in_data_i   (slv_req_i.ar),
    .out_valid_o (ar_out_valid),
    .out_ready_i (ar_out_ready),
    .out_data_o  (ar_out)
  );

  assign ar_out_ready = tgt_resp[rd_sel].ar_ready;
  assign r_in         = tgt_resp[rd_sel_q].r;
  assign r_in_valid   = rd_pend_q && tgt_resp[rd_sel_q].r_valid;

  axil_slice #(.payload_t(axil_pkg::r_t)) r_slice_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (r_in_valid),
    .in_ready_o  (r_in_ready),
    .in_data_i   (r_in),
    .out_valid_o (r_out_valid),
    .out_ready_i (slv_req_i.r_ready),
    .out_data_o  (r_out)
  );

  // --------------------------------------------------
  // routing
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < NrTgt; i++) begin
      tgt_req[i]          = '0;
      tgt_req[i].aw       = slv_req_i.aw;
      tgt_req[i].w        = slv_req_i.w;
      tgt_req[i].ar       = ar_out;
      tgt_req[i].aw_valid = slv_req_i.aw_valid && !wr_pend_q && (wr_sel == SelW'(i));
      tgt_req[i].w_valid  = slv_req_i.w_valid && !wr_pend_q && (wr_sel == SelW'(i));
      tgt_req[i].b_ready  = slv_req_i.b_ready && wr_pend_q && (wr_sel_q == SelW'(i));
      tgt_req[i].ar_valid = ar_out_valid && (rd_sel == SelW'(i));
      tgt_req[i].r_ready  = r_in_ready && rd_pend_q && (rd_sel_q == SelW'(i));
    end
    for (int i = 0; i < soc_map_pkg::NrSlaves; i++) begin
      mst_req_o[i] = tgt_req[i];
    end
  end

  always_comb begin
    for (int i = 0; i < soc_map_pkg::NrSlaves; i++) begin
      tgt_resp[i] = mst_resp_i[i];
    end
    // error responder takes AW and W together like the real slaves
    tgt_resp[ErrIdx]          = '0;
    tgt_resp[ErrIdx].aw_ready = tgt_req[ErrIdx].aw_valid && tgt_req[ErrIdx].w_valid && !err_b_q;
    tgt_resp[ErrIdx].w_ready  = tgt_req[ErrIdx].aw_valid && tgt_req[ErrIdx].w_valid && !err_b_q;
    tgt_resp[ErrIdx].b_valid  = err_b_q;
    tgt_resp[ErrIdx].b.resp   = axil_pkg::RESP_DECERR;
    tgt_resp[ErrIdx].ar_ready = tgt_req[ErrIdx].ar_valid && !err_r_q;
    tgt_resp[ErrIdx].r_valid  = err_r_q;
    tgt_resp[ErrIdx].r.resp   = axil_pkg::RESP_DECERR; // data stays zero
  end

  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.aw_ready = !wr_pend_q && tgt_resp[wr_sel].aw_ready;
    slv_resp_o.w_ready  = !wr_pend_q && tgt_resp[wr_sel].w_ready;
    slv_resp_o.b        = tgt_resp[wr_sel_q].b;
    slv_resp_o.b_valid  = wr_pend_q && tgt_resp[wr_sel_q].b_valid;
    slv_resp_o.ar_ready = ar_in_valid && ar_in_ready;
    slv_resp_o.r        = r_out;
    slv_resp_o.r_valid  = r_out_valid;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_busy_q <= 1'b0;
      rd_pend_q <= 1'b0;
      rd_sel_q  <= '0;
      wr_pend_q <= 1'b0;
      wr_sel_q  <= '0;
      err_b_q   <= 1'b0;
      err_r_q   <= 1'b0;
    end else begin
      if (ar_in_valid && ar_in_ready) begin
        rd_busy_q <= 1'b1;
      end else if (r_out_valid && slv_req_i.r_ready) begin
        rd_busy_q <= 1'b0;
      end
      if (ar_out_valid && ar_out_ready) begin
        rd_pend_q <= 1'b1;
        rd_sel_q  <= rd_sel;
      end else if (r_in_valid && r_in_ready) begin
        rd_pend_q <= 1'b0;
      end
      if (slv_req_i.aw_valid && slv_resp_o.aw_ready) begin
        wr_pend_q <= 1'b1;
        wr_sel_q  <= wr_sel;
      end else if (slv_resp_o.b_valid && slv_req_i.b_ready) begin
        wr_pend_q <= 1'b0;
      end
      if (tgt_req[ErrIdx].aw_valid && tgt_resp[ErrIdx].aw_ready) begin
        err_b_q <= 1'b1;
      end else if (tgt_req[ErrIdx].b_ready) begin
        err_b_q <= 1'b0;
      end
      if (tgt_req[ErrIdx].ar_valid && tgt_resp[ErrIdx].ar_ready) begin
        err_r_q <= 1'b1;
      end else if (tgt_req[ErrIdx].r_ready) begin
        err_r_q <= 1'b0;
      end
    end
  end

  // target stays put until its response has been taken
  assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_pend_q && !(r_in_valid && r_in_ready) |=> rd_pend_q && $stable(rd_sel_q));
  assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_pend_q && !(slv_resp_o.b_valid && slv_req_i.b_ready) |=> wr_pend_q && $stable(wr_sel_q));

endmodule

`default_nettype wire

/* source/clint.sv */
/*
 * Core-local interruptor behind an AXI4-Lite slave: msip,
 * 64-bit mtimecmp and mtime with byte strobes, real-time
 * prescaler, timer and software interrupt outputs
 */
`timescale 1ns/1ps
`default_nettype none

module clint #(
  parameter int unsigned RtcDiv = 2
) (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire axil_pkg::req_t  req_i,
  output axil_pkg::resp_t      resp_o,
  output logic                 timer_irq_o,
  output logic                 ipi_o
);

  localparam int unsigned CntW = (RtcDiv > 1) ? $clog2(RtcDiv) : 1;

  logic                           msip_q;
  logic [63:0]                    mtimecmp_q, mtime_q;
  logic [CntW-1:0]                div_cnt_q;
  logic                           tick;
  logic                           wr_hs, rd_hs;
  logic                           b_valid_q, r_valid_q;
  logic [15:0]                    wr_off, rd_off;
  logic [axil_pkg::DataWidth-1:0] rd_data, r_data_q;

  function automatic logic [63:0] apply_strb(input logic [63:0] old_val,
                                             input logic [63:0] new_val,
                                             input logic [axil_pkg::StrbWidth-1:0] strb);
    logic [63:0] res;
    res = old_val;
    for (int b = 0; b < axil_pkg::StrbWidth; b++) begin
      if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  assign wr_off = req_i.aw.addr[15:0];
  assign rd_off = req_i.ar.addr[15:0];
  assign wr_hs  = req_i.aw_valid && req_i.w_valid && !b_valid_q;
  assign rd_hs  = req_i.ar_valid && !r_valid_q;
  assign tick   = (div_cnt_q == CntW'(RtcDiv - 1));

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = wr_hs;
    resp_o.w_ready  = wr_hs;
    resp_o.b_valid  = b_valid_q;
    resp_o.b.resp   = axil_pkg::RESP_OKAY;
    resp_o.ar_ready = rd_hs;
    resp_o.r_valid  = r_valid_q;
    resp_o.r.data   = r_data_q;
    resp_o.r.resp   = axil_pkg::RESP_OKAY;
  end

  // --------------------------------------------------
  // register file
  // --------------------------------------------------
  always_comb begin
    rd_data = '0; // holes read zero
    if (rd_off[15:3] == soc_map_pkg::MsipOffset[15:3]) begin
      rd_data = {63'b0, msip_q};
    end else if (rd_off[15:3] == soc_map_pkg::MtimecmpOffset[15:3]) begin
      rd_data = mtimecmp_q;
    end else if (rd_off[15:3] == soc_map_pkg::MtimeOffset[15:3]) begin
      rd_data = mtime_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      div_cnt_q  <= '0;
      b_valid_q  <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      div_cnt_q <= tick ? '0 : div_cnt_q + 1'b1;
      if (tick) mtime_q <= mtime_q + 64'd1;
      if (wr_hs) begin
        b_valid_q <= 1'b1;
        if (wr_off[15:3] == soc_map_pkg::MsipOffset[15:3] && req_i.w.strb[0]) begin
          msip_q <= req_i.w.data[0];
        end
        if (wr_off[15:3] == soc_map_pkg::MtimecmpOffset[15:3]) begin
          mtimecmp_q <= apply_strb(mtimecmp_q, req_i.w.data, req_i.w.strb);
        end
        if (wr_off[15:3] == soc_map_pkg::MtimeOffset[15:3]) begin
          mtime_q <= apply_strb(mtime_q, req_i.w.data, req_i.w.strb); // beats the tick
        end
      end else if (req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) r_data_q <= rd_data;
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

  assert property (@(posedge clk) $rose(rst_n_i) |-> !timer_irq_o);

endmodule

`default_nettype wire

/* source/boot_rom.sv */
/*
 * Boot ROM as a read-only AXI4-Lite slave,
 * words past RomWords read zero, writes get SLVERR
 */
`timescale 1ns/1ps
`default_nettype none

module boot_rom #(
  parameter int unsigned RomWords = soc_map_pkg::BootImageWords
) (
  input  wire logic           clk,
  input  wire logic           rst_n_i,
  input  wire axil_pkg::req_t req_i,
  output axil_pkg::resp_t     resp_o
);

  localparam int unsigned OffW = $clog2(soc_map_pkg::RomLength);
  localparam int unsigned IdxW = $clog2(soc_map_pkg::BootImageWords);

  logic                           wr_hs, rd_hs;
  logic                           b_valid_q, r_valid_q;
  logic [OffW-4:0]                rd_idx;
  logic [axil_pkg::DataWidth-1:0] r_data_q;

  assign rd_idx = req_i.ar.addr[OffW-1:3]; // word index
  assign wr_hs  = req_i.aw_valid && req_i.w_valid && !b_valid_q;
  assign rd_hs  = req_i.ar_valid && !r_valid_q;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = wr_hs;
    resp_o.w_ready  = wr_hs;
    resp_o.b_valid  = b_valid_q;
    resp_o.b.resp   = axil_pkg::RESP_SLVERR; // read-only
    resp_o.ar_ready = rd_hs;
    resp_o.r_valid  = r_valid_q;
    resp_o.r.data   = r_data_q;
    resp_o.r.resp   = axil_pkg::RESP_OKAY;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_hs) b_valid_q <= 1'b1;
      else if (req_i.b_ready) b_valid_q <= 1'b0;
      if (rd_hs) r_valid_q <= 1'b1;
      else if (req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      r_data_q <= (rd_idx < RomWords) ? soc_map_pkg::BootImage[rd_idx[IdxW-1:0]] : '0;
    end
  end

  initial assert (RomWords <= soc_map_pkg::BootImageWords);

endmodule

`default_nettype wire

/* source/soc_top.sv */
/*
 * SoC memory-mapped core: reset generation, interconnect,
 * boot ROM and CLINT
 */
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int unsigned SyncStages = 2,
  parameter int unsigned RtcDiv     = 2,
  parameter int unsigned RomWords   = soc_map_pkg::BootImageWords
) (
  input  wire logic           clk,
  input  wire logic           ndmreset_n,
  input  wire logic           pll_locked_i,
  input  wire axil_pkg::req_t axil_req_i,
  output axil_pkg::resp_t     axil_resp_o,
  output logic                timer_irq_o,
  output logic                ipi_o
);

  logic            sys_rst_n;
  axil_pkg::req_t  tgt_req  [soc_map_pkg::NrSlaves];
  axil_pkg::resp_t tgt_resp [soc_map_pkg::NrSlaves];

  reset_gen #(.SyncStages(SyncStages)) reset_gen_i (
    .clk          (clk),
    .ndmreset_n   (ndmreset_n),
    .pll_locked_i (pll_locked_i),
    .sys_rst_n_o  (sys_rst_n)
  );

  axil_xbar xbar_i (
    .clk        (clk),
    .rst_n_i    (sys_rst_n),
    .slv_req_i  (axil_req_i),
    .slv_resp_o (axil_resp_o),
    .mst_req_o  (tgt_req),
    .mst_resp_i (tgt_resp)
  );

  boot_rom #(.RomWords(RomWords)) boot_rom_i (
    .clk     (clk),
    .rst_n_i (sys_rst_n),
    .req_i   (tgt_req[soc_map_pkg::ROM_IDX]),
    .resp_o  (tgt_resp[soc_map_pkg::ROM_IDX])
  );

  clint #(.RtcDiv(RtcDiv)) clint_i (
    .clk         (clk),
    .rst_n_i     (sys_rst_n),
    .req_i       (tgt_req[soc_map_pkg::CLINT_IDX]),
    .resp_o      (tgt_resp[soc_map_pkg::CLINT_IDX]),
    .timer_irq_o (timer_irq_o),
    .ipi_o       (ipi_o)
  );

endmodule

`default_nettype wire

/* verif/tb_soc.sv */
/*
 * Testbench for the SoC core with clock and reset, AXI4-Lite read
 * and write tasks, directed tests, timeout and verdict
 */
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

  localparam int unsigned SyncStages    = 2;
  localparam int unsigned RtcDiv        = 2;
  localparam int unsigned RomWords      = soc_map_pkg::BootImageWords;
  localparam int unsigned TimeoutCycles = 2000;
  localparam int unsigned MtimeGap      = 100;
  localparam int unsigned MtimeExpected = MtimeGap / RtcDiv; // ticks in the gap
  localparam logic [31:0] UnmappedAddr  = 32'h1000_0000;

  logic            clk;
  logic            ndmreset_n;
  logic            pll_locked;
  logic            timer_irq;
  logic            ipi;
  axil_pkg::req_t  axil_req;
  axil_pkg::resp_t axil_resp;
  logic [31:0]     rng_state = 32'h6b64;
  int unsigned     cycles = 0;

  soc_top #(
    .SyncStages (SyncStages),
    .RtcDiv     (RtcDiv),
    .RomWords   (RomWords)
  ) soc_top_i (
    .clk          (clk),
    .ndmreset_n   (ndmreset_n),
    .pll_locked_i (pll_locked),
    .axil_req_i   (axil_req),
    .axil_resp_o  (axil_resp),
    .timer_irq_o  (timer_irq),
    .ipi_o        (ipi)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Something failed");
      $fatal(1, "run aborted");
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [31:0] clint_addr(input logic [15:0] offset);
    return soc_map_pkg::ClintBase + {16'b0, offset};
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got == exp) else begin
      report_failure($sformatf("Error at time %0t: %s expected %h, got %h",
                               $time, name, exp, got));
    end
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [63:0] data,
                           output axil_pkg::resp_e resp);
    @(negedge clk);
    axil_req.ar.addr  = addr;
    axil_req.ar.prot  = 3'b000;
    axil_req.ar_valid = 1'b1;
    axil_req.r_ready  = 1'b1;
    do @(posedge clk); while (!axil_resp.ar_ready); // accepted at this edge
    @(negedge clk);
    axil_req.ar_valid = 1'b0;
    while (!axil_resp.r_valid) @(negedge clk);
    data = axil_resp.r.data;
    resp = axil_resp.r.resp;
    @(negedge clk); // r taken on the edge before
    axil_req.r_ready = 1'b0;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [axil_pkg::StrbWidth-1:0] strb,
                            output axil_pkg::resp_e resp);
    @(negedge clk);
    axil_req.aw.addr  = addr;
    axil_req.aw.prot  = 3'b000;
    axil_req.aw_valid = 1'b1;
    axil_req.w.data   = data;
    axil_req.w.strb   = strb;
    axil_req.w_valid  = 1'b1;
    axil_req.b_ready  = 1'b1;
    do @(posedge clk); while (!axil_resp.aw_ready); // aw and w go together
    check_value("w_ready", axil_resp.w_ready, 1'b1);
    @(negedge clk);
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    while (!axil_resp.b_valid) @(negedge clk);
    resp = axil_resp.b.resp;
    @(negedge clk);
    axil_req.b_ready = 1'b0;
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    check_value("aw_ready", axil_resp.aw_ready, 1'b0);
    check_value("w_ready", axil_resp.w_ready, 1'b0);
    check_value("ar_ready", axil_resp.ar_ready, 1'b0);
    check_value("r_valid", axil_resp.r_valid, 1'b0);
    check_value("b_valid", axil_resp.b_valid, 1'b0);
    check_value("timer_irq_o", timer_irq, 1'b0);
    check_value("ipi_o", ipi, 1'b0);
  endtask

  task automatic test_rom();
    logic [63:0]     data;
    logic [63:0]     wdata;
    axil_pkg::resp_e resp;
    int unsigned     idx;
    for (int k = 0; k < RomWords; k++) begin
      axil_read(soc_map_pkg::RomBase + 32'(8 * k), data, resp);
      check_value("r.data", data, soc_map_pkg::BootImage[k]);
      check_value("r.resp", resp, axil_pkg::RESP_OKAY);
    end
    axil_read(soc_map_pkg::RomBase + 32'(8 * 12), data, resp); // past the image
    check_value("r.data", data, 64'h0);
    check_value("r.resp", resp, axil_pkg::RESP_OKAY);
    idx   = next_rand() % RomWords;
    wdata = {next_rand(), next_rand()};
    axil_write(soc_map_pkg::RomBase + 32'(8 * idx), wdata, '1, resp);
    check_value("b.resp", resp, axil_pkg::RESP_SLVERR);
    axil_read(soc_map_pkg::RomBase + 32'(8 * idx), data, resp);
    check_value("r.data", data, soc_map_pkg::BootImage[idx]);
  endtask

  task automatic test_unmapped();
    logic [63:0]     data;
    axil_pkg::resp_e resp;
    axil_read(UnmappedAddr, data, resp);
    check_value("r.data", data, 64'h0);
    check_value("r.resp", resp, axil_pkg::RESP_DECERR);
    axil_write(UnmappedAddr, {next_rand(), next_rand()}, '1, resp);
    check_value("b.resp", resp, axil_pkg::RESP_DECERR);
  endtask

  task automatic test_msip();
    logic [63:0]     data;
    axil_pkg::resp_e resp;
    axil_write(clint_addr(soc_map_pkg::MsipOffset), 64'h1, '1, resp);
    check_value("b.resp", resp, axil_pkg::RESP_OKAY);
    check_value("ipi_o", ipi, 1'b1);
    axil_read(clint_addr(soc_map_pkg::MsipOffset), data, resp);
    check_value("r.data", data, 64'h1);
    axil_write(clint_addr(soc_map_pkg::MsipOffset), 64'h0, '1, resp);
    check_value("ipi_o", ipi, 1'b0);
  endtask

  task automatic test_timer();
    logic [63:0]     mtime;
    logic [63:0]     cmp;
    logic [63:0]     data;
    logic [63:0]     delta;
    axil_pkg::resp_e resp;
    int unsigned     waited;
    axil_read(clint_addr(soc_map_pkg::MtimeOffset), mtime, resp);
    cmp = mtime + 64'd40;
    axil_write(clint_addr(soc_map_pkg::MtimecmpOffset), cmp, '1, resp);
    check_value("b.resp", resp, axil_pkg::RESP_OKAY);
    check_value("timer_irq_o", timer_irq, 1'b0);
    waited = 0;
    while (!timer_irq && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    assert (timer_irq) else begin
      report_failure("timer_irq_o did not rise within 200 cycles of the compare write");
    end
    // only the low word changes
    axil_write(clint_addr(soc_map_pkg::MtimecmpOffset), '1, 8'h0F, resp);
    check_value("timer_irq_o", timer_irq, 1'b0);
    axil_read(clint_addr(soc_map_pkg::MtimecmpOffset), data, resp);
    check_value("mtimecmp", data, {cmp[63:32], 32'hFFFF_FFFF});
    axil_read(clint_addr(soc_map_pkg::MtimeOffset), mtime, resp);
    repeat (MtimeGap) @(negedge clk);
    axil_read(clint_addr(soc_map_pkg::MtimeOffset), data, resp);
    delta = data - mtime;
    assert (delta >= MtimeExpected - 10 && delta <= MtimeExpected + 10) else begin
      report_failure($sformatf("Error at time %0t: mtime delta expected %0d to %0d, got %0d",
                               $time, MtimeExpected - 10, MtimeExpected + 10, delta));
    end
  endtask

  task automatic test_lock_reset();
    logic [63:0]     data;
    axil_pkg::resp_e resp;
    axil_write(clint_addr(soc_map_pkg::MsipOffset), 64'h1, '1, resp);
    check_value("ipi_o", ipi, 1'b1);
    @(negedge clk);
    pll_locked = 1'b0;
    repeat (3) @(negedge clk);
    check_value("ipi_o", ipi, 1'b0);
    pll_locked = 1'b1;
    repeat (SyncStages + 1) @(negedge clk); // wait for release
    axil_read(clint_addr(soc_map_pkg::MsipOffset), data, resp);
    check_value("r.data", data, 64'h0);
  endtask

  initial begin
    ndmreset_n = 1'b0;
    pll_locked = 1'b1;
    axil_req   = '0;
    repeat (5) @(negedge clk);
    ndmreset_n = 1'b1;
    repeat (SyncStages + 1) @(negedge clk);
    test_reset_state();
    test_rom();
    test_unmapped();
    test_msip();
    test_timer();
    test_lock_reset();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
source/axil_pkg.sv
source/soc_map_pkg.sv
source/reset_gen.sv
source/axil_slice.sv
source/axil_xbar.sv
source/clint.sv
source/boot_rom.sv
source/soc_top.sv
verif/tb_soc.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f build.f &&
./obj_dir/Vtb_soc | tee /dev/stderr | grep -qx "Everything OK" ||
{ echo "simulation did not pass"; exit 1; }
